/* Makefile */
# Verilator build and run of the packet parser testbench
# override any variable on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_pkt_parser
RTL_TOP   ?= pkt_parser_top
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* build.f */
logic/pkt_defs_pkg.sv
logic/parser_regs_pkg.sv
logic/pkt_unpack.sv
logic/pkt_filter.sv
logic/parser_apb_regs.sv
logic/pkt_parser_top.sv
sim/tb_pkt_parser.sv

/* logic/parser_apb_regs.sv */
/*
  APB slave, pready tied high, no wait states
  pslverr on unmapped offsets and on writes to read-only registers
  resync and count_clear pulse one cycle after the write edge
*/
`timescale 1ns/1ps
`default_nettype none

module parser_apb_regs
(
   input  logic                        clk,
   input  logic                        rst,
   input  parser_regs_pkg::apb_req_t   apb_req,
   input  pkt_defs_pkg::unpack_state_t phase,
   input  parser_regs_pkg::count_t     accept_cnt,
   input  parser_regs_pkg::count_t     drop_cnt,
   output parser_regs_pkg::apb_rsp_t   apb_rsp,
   output logic                        enable,
   output logic                        resync,
   output logic                        count_clear,
   output parser_regs_pkg::match_cfg_t match
);

   logic access;
   logic mapped;
   logic read_only;
   logic wr_ok;

   assign access = apb_req.psel && apb_req.penable;

   // address decode and read mux
   always_comb
   begin
      mapped         = 1'b1;
      read_only      = 1'b0;
      apb_rsp.prdata = '0;
      case (apb_req.paddr)
         parser_regs_pkg::CTRL:
            apb_rsp.prdata = {31'd0, enable};
         parser_regs_pkg::MATCH:
            apb_rsp.prdata = {16'd0, match};
         parser_regs_pkg::ACCEPT_CNT:
         begin
            read_only      = 1'b1;
            apb_rsp.prdata = {16'd0, accept_cnt};
         end
         parser_regs_pkg::DROP_CNT:
         begin
            read_only      = 1'b1;
            apb_rsp.prdata = {16'd0, drop_cnt};
         end
         parser_regs_pkg::STATUS:
         begin
            read_only      = 1'b1;
            // phase in the low two bits
            apb_rsp.prdata = {30'd0, phase};
         end
         default:
            mapped = 1'b0;
      endcase
   end

   assign apb_rsp.pready  = 1'b1;
   assign apb_rsp.pslverr = access && (!mapped || (apb_req.pwrite && read_only));
   // erroring writes change nothing
   assign wr_ok = access && apb_req.pwrite && mapped && !read_only;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         enable      <= 1'b0;
         resync      <= 1'b0;
         count_clear <= 1'b0;
         match       <= '0;
      end
      else
      begin
         // command bits self clear
         resync      <= wr_ok && apb_req.paddr == parser_regs_pkg::CTRL &&
                        apb_req.pwdata[1];
         count_clear <= wr_ok && apb_req.paddr == parser_regs_pkg::CTRL &&
                        apb_req.pwdata[2];
         if (wr_ok && apb_req.paddr == parser_regs_pkg::CTRL)
            enable <= apb_req.pwdata[0];
         if (wr_ok && apb_req.paddr == parser_regs_pkg::MATCH)
            match <= apb_req.pwdata[15:0];
      end
   end

   // an APB access takes two cycles, so commands never repeat back to back
   a_resync_pulse: assert property (@(posedge clk) disable iff (rst)
      resync |=> !resync);
   a_clear_pulse: assert property (@(posedge clk) disable iff (rst)
      count_clear |=> !count_clear);

endmodule

`default_nettype wire

/* logic/parser_regs_pkg.sv */
/*
  APB bus types and register map of the parser
  8-bit byte addresses, 32-bit data, no wait states
*/
`default_nettype none

package parser_regs_pkg;

   typedef logic [7:0]  apb_addr_t;
   typedef logic [31:0] apb_data_t;

   typedef struct packed {
      logic      psel;
      logic      penable;
      logic      pwrite;
      apb_addr_t paddr;
      apb_data_t pwdata;
   } apb_req_t;

   typedef struct packed {
      apb_data_t prdata;
      logic      pready;
      logic      pslverr;
   } apb_rsp_t;

   // register offsets
   localparam apb_addr_t CTRL       = 8'h00;
   localparam apb_addr_t MATCH      = 8'h04;
   localparam apb_addr_t ACCEPT_CNT = 8'h08;
   localparam apb_addr_t DROP_CNT   = 8'h0C;
   localparam apb_addr_t STATUS     = 8'h10;

   typedef logic [15:0] count_t;

   // value sits in bits 7:0, mask in bits 15:8
   typedef struct packed {
      pkt_defs_pkg::f0_t mask;
      pkt_defs_pkg::f0_t value;
   } match_cfg_t;

endpackage

`default_nettype wire

/* logic/pkt_defs_pkg.sv */
/*
  fixed 96-bit packet layout, three 32-bit words per packet
  f2 and f3 span word boundaries, their low pieces come first
  one layout only, all widths follow from it
*/
`default_nettype none

package pkt_defs_pkg;

   typedef logic [31:0] word_t;

   // field types
   typedef logic [7:0]  f0_t;
   typedef logic [15:0] f1_t;
   typedef logic [15:0] f2_t;
   typedef logic [31:0] f3_t;
   typedef logic [23:0] f4_t;

   localparam int WORDS_PER_PKT = 3;

   // piece positions inside each word
   localparam int F0_W0_MSB = 31;
   localparam int F0_W0_LSB = 24;
   localparam int F1_W0_MSB = 23;
   localparam int F1_W0_LSB = 8;
   localparam int F2_W0_MSB = 7;
   localparam int F2_W0_LSB = 0;
   localparam int F2_W1_MSB = 31;
   localparam int F2_W1_LSB = 24;
   localparam int F3_W1_MSB = 23;
   localparam int F3_W1_LSB = 0;
   localparam int F3_W2_MSB = 31;
   localparam int F3_W2_LSB = 24;
   localparam int F4_W2_MSB = 23;
   localparam int F4_W2_LSB = 0;

   // widths of the held low pieces
   localparam int F2_LO_W = F2_W0_MSB - F2_W0_LSB + 1;
   localparam int F3_LO_W = F3_W1_MSB - F3_W1_LSB + 1;

   // bit index of each field in the valid mask
   localparam int V_F0 = 0;
   localparam int V_F1 = 1;
   localparam int V_F2 = 2;
   localparam int V_F3 = 3;
   localparam int V_F4 = 4;

   typedef enum logic [$clog2(WORDS_PER_PKT)-1:0] {
      WORD0 = 0,
      WORD1 = 1,
      WORD2 = 2
   } unpack_state_t;

   typedef struct packed {
      f0_t        f0;
      f1_t        f1;
      f2_t        f2;
      f3_t        f3;
      f4_t        f4;
      logic [4:0] valid;
   } pkt_fields_t;

   typedef struct packed {
      f0_t f0;
      f1_t f1;
      f2_t f2;
      f3_t f3;
      f4_t f4;
   } pkt_record_t;

endpackage

`default_nettype wire

/* logic/pkt_filter.sv */
/*
  record builder and f0 type filter, one cycle after word2
  mask 0 accepts everything, counters saturate
  count_clear wins over a count step in the same cycle
*/
`timescale 1ns/1ps
`default_nettype none

module pkt_filter
(
   input  logic                        clk,
   input  logic                        rst,
   input  pkt_defs_pkg::pkt_fields_t   fields,
   input  parser_regs_pkg::match_cfg_t match,
   input  logic                        count_clear,
   output pkt_defs_pkg::pkt_record_t   rec,
   output logic                        rec_valid,
   output parser_regs_pkg::count_t     accept_cnt,
   output parser_regs_pkg::count_t     drop_cnt
);

   // fields from earlier words of the packet
   pkt_defs_pkg::f0_t f0_q;
   pkt_defs_pkg::f1_t f1_q;
   pkt_defs_pkg::f2_t f2_q;
   logic              last;
   logic              hit;

   assign last = fields.valid[pkt_defs_pkg::V_F4];
   // equal in every masked bit
   assign hit  = ((f0_q ^ match.value) & match.mask) == '0;

   always_ff @(posedge clk)
   begin
      if (fields.valid[pkt_defs_pkg::V_F0])
         f0_q <= fields.f0;
      if (fields.valid[pkt_defs_pkg::V_F1])
         f1_q <= fields.f1;
      if (fields.valid[pkt_defs_pkg::V_F2])
         f2_q <= fields.f2;
      // f3 and f4 straight from the word2 cycle
      if (last && hit)
      begin
         rec.f0 <= f0_q;
         rec.f1 <= f1_q;
         rec.f2 <= f2_q;
         rec.f3 <= fields.f3;
         rec.f4 <= fields.f4;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rec_valid  <= 1'b0;
         accept_cnt <= '0;
         drop_cnt   <= '0;
      end
      else
      begin
         rec_valid <= last && hit;
         if (count_clear)
         begin
            accept_cnt <= '0;
            drop_cnt   <= '0;
         end
         else if (last && hit && accept_cnt != '1)
            accept_cnt <= accept_cnt + 1'b1;
         else if (last && !hit && drop_cnt != '1)
            drop_cnt <= drop_cnt + 1'b1;
      end
   end

   // a record only follows the last word of a packet
   a_rec_after_last: assert property (@(posedge clk) disable iff (rst)
      rec_valid |-> $past(last));

endmodule

`default_nettype wire

/* logic/pkt_parser_top.sv */
/*
  packet parser top, unpacker then filter, APB control
  valid-only input stream, every word with din_v is taken when enabled
*/
`timescale 1ns/1ps
`default_nettype none

module pkt_parser_top
(
   input  logic                      clk,
   input  logic                      rst,
   input  pkt_defs_pkg::word_t       din,
   input  logic                      din_v,
   input  parser_regs_pkg::apb_req_t apb_req,
   output parser_regs_pkg::apb_rsp_t apb_rsp,
   output pkt_defs_pkg::pkt_record_t rec,
   output logic                      rec_valid
);

   pkt_defs_pkg::pkt_fields_t   fields;
   pkt_defs_pkg::unpack_state_t phase;
   parser_regs_pkg::match_cfg_t match;
   parser_regs_pkg::count_t     accept_cnt;
   parser_regs_pkg::count_t     drop_cnt;
   logic                        enable;
   logic                        resync;
   logic                        count_clear;

   // word stream to fields
   pkt_unpack i_pkt_unpack (
      .clk    (clk),
      .rst    (rst),
      .din    (din),
      .din_v  (din_v),
      .enable (enable),
      .resync (resync),
      .fields (fields),
      .phase  (phase)
   );

   // fields to filtered records
   pkt_filter i_pkt_filter (
      .clk         (clk),
      .rst         (rst),
      .fields      (fields),
      .match       (match),
      .count_clear (count_clear),
      .rec         (rec),
      .rec_valid   (rec_valid),
      .accept_cnt  (accept_cnt),
      .drop_cnt    (drop_cnt)
   );

   parser_apb_regs i_parser_apb_regs (
      .clk         (clk),
      .rst         (rst),
      .apb_req     (apb_req),
      .phase       (phase),
      .accept_cnt  (accept_cnt),
      .drop_cnt    (drop_cnt),
      .apb_rsp     (apb_rsp),
      .enable      (enable),
      .resync      (resync),
      .count_clear (count_clear),
      .match       (match)
   );

endmodule

`default_nettype wire

/* logic/pkt_unpack.sv */
/*
  word unpacker, fields are combinational from the accepted word
  words are taken only while enable is high, no back-pressure
  resync in the same cycle as a word makes that word word0
*/
`timescale 1ns/1ps
`default_nettype none

module pkt_unpack
(
   input  logic                        clk,
   input  logic                        rst,
   input  pkt_defs_pkg::word_t         din,
   input  logic                        din_v,
   input  logic                        enable,
   input  logic                        resync,
   output pkt_defs_pkg::pkt_fields_t   fields,
   output pkt_defs_pkg::unpack_state_t phase
);

   pkt_defs_pkg::unpack_state_t state;
   pkt_defs_pkg::unpack_state_t eff_state;
   pkt_defs_pkg::unpack_state_t next_state;
   logic                        accept;

   // held low pieces of the spanning fields
   logic [pkt_defs_pkg::F2_LO_W-1:0] f2_lo;
   logic [pkt_defs_pkg::F3_LO_W-1:0] f3_lo;

   assign accept    = din_v && enable;
   // resync acts at once on the decode
   assign eff_state = resync ? pkt_defs_pkg::WORD0 : state;
   assign phase     = state;

   always_comb
   begin
      next_state   = eff_state;
      // data follows din, valid bits qualify it
      fields.f0    = din[pkt_defs_pkg::F0_W0_MSB:pkt_defs_pkg::F0_W0_LSB];
      fields.f1    = din[pkt_defs_pkg::F1_W0_MSB:pkt_defs_pkg::F1_W0_LSB];
      fields.f2    = {din[pkt_defs_pkg::F2_W1_MSB:pkt_defs_pkg::F2_W1_LSB], f2_lo};
      fields.f3    = {din[pkt_defs_pkg::F3_W2_MSB:pkt_defs_pkg::F3_W2_LSB], f3_lo};
      fields.f4    = din[pkt_defs_pkg::F4_W2_MSB:pkt_defs_pkg::F4_W2_LSB];
      fields.valid = '0;
      case (eff_state)
         pkt_defs_pkg::WORD0:
         begin
            // f0 and f1 live wholly in word0
            if (accept)
            begin
               fields.valid[pkt_defs_pkg::V_F0] = 1'b1;
               fields.valid[pkt_defs_pkg::V_F1] = 1'b1;
               next_state = pkt_defs_pkg::WORD1;
            end
         end
         pkt_defs_pkg::WORD1:
         begin
            // f2 completes here
            if (accept)
            begin
               fields.valid[pkt_defs_pkg::V_F2] = 1'b1;
               next_state = pkt_defs_pkg::WORD2;
            end
         end
         pkt_defs_pkg::WORD2:
         begin
            // f3 completes, f4 whole
            if (accept)
            begin
               fields.valid[pkt_defs_pkg::V_F3] = 1'b1;
               fields.valid[pkt_defs_pkg::V_F4] = 1'b1;
               next_state = pkt_defs_pkg::WORD0;
            end
         end
         default:
         begin
            next_state = pkt_defs_pkg::WORD0;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         state <= pkt_defs_pkg::WORD0;
      else
         state <= next_state;
   end

   // low pieces, a new word overrides the resync clear
   always_ff @(posedge clk)
   begin
      if (resync)
      begin
         f2_lo <= '0;
         f3_lo <= '0;
      end
      if (accept && eff_state == pkt_defs_pkg::WORD0)
         f2_lo <= din[pkt_defs_pkg::F2_W0_MSB:pkt_defs_pkg::F2_W0_LSB];
      if (accept && eff_state == pkt_defs_pkg::WORD1)
         f3_lo <= din[pkt_defs_pkg::F3_W1_MSB:pkt_defs_pkg::F3_W1_LSB];
   end

   // field valids only ever come from a taken word
   a_valid_needs_word: assert property (@(posedge clk) disable iff (rst)
      (|fields.valid) |-> (din_v && enable));

endmodule

`default_nettype wire

/* sim/tb_pkt_parser.sv */
/*
  random packets from a fixed seed, one record model queue
  checks are assertions, a record is expected one cycle after word2
  full packets are only sent while the unpacker sits at word0
*/
`timescale 1ns/1ps
`default_nettype none

module tb_pkt_parser;

   localparam int          PERIOD   = 40;
   localparam logic [31:0] SEED     = 32'h42fb_e9d1;
   localparam int          MAX_GAP  = 3;
   localparam int          N_SPLIT  = 24;
   localparam int          N_B2B    = 8;
   localparam int          N_FILTER = 24;
   // upper bound on packets sent, APB traffic goes into the margin
   localparam int          N_PKT    = N_SPLIT + N_B2B + N_FILTER + 8;
   localparam longint      WATCHDOG = longint'(N_PKT) * 3 * (MAX_GAP + 1) * PERIOD
                                      + 1000 * PERIOD;

   logic                      clk;
   logic                      rst;
   pkt_defs_pkg::word_t       din;
   logic                      din_v;
   parser_regs_pkg::apb_req_t apb_req;
   parser_regs_pkg::apb_rsp_t apb_rsp;
   pkt_defs_pkg::pkt_record_t rec;
   logic                      rec_valid;

   // reference model
   pkt_defs_pkg::pkt_record_t exp_q[$];
   pkt_defs_pkg::pkt_record_t exp_rec;
   logic                      exp_valid;
   logic                      acc_mark;
   logic [7:0]                m_value;
   logic [7:0]                m_mask;
   int                        m_accept;
   int                        m_drop;
   int                        errors;
   int                        tests_failed;

   pkt_parser_top i_pkt_parser_top (
      .clk       (clk),
      .rst       (rst),
      .din       (din),
      .din_v     (din_v),
      .apb_req   (apb_req),
      .apb_rsp   (apb_rsp),
      .rec       (rec),
      .rec_valid (rec_valid)
   );

   always #(PERIOD / 2) clk = ~clk;

   // acc_mark rides with an accepted word2, the record follows one edge later
   always @(posedge clk)
   begin
      if (rst)
         exp_valid <= 1'b0;
      else
      begin
         exp_valid <= acc_mark;
         if (acc_mark)
            exp_rec <= exp_q.pop_front();
      end
   end

   a_rec_timing: assert property (@(posedge clk) disable iff (rst)
      rec_valid == exp_valid)
   else
   begin
      errors++;
      $display("Mismatch at %0t: rec_valid %b, model %b", $time,
               $sampled(rec_valid), $sampled(exp_valid));
   end

   a_rec_value: assert property (@(posedge clk) disable iff (rst)
      exp_valid |-> rec == exp_rec)
   else
   begin
      errors++;
      $display("Mismatch at %0t: record %h, model %h", $time,
               $sampled(rec), $sampled(exp_rec));
   end

   a_pready: assert property (@(posedge clk) disable iff (rst) apb_rsp.pready)
   else
   begin
      errors++;
      $display("Mismatch at %0t: pready low, expected 1", $time);
   end

   // split written out from the packet layout
   function automatic pkt_defs_pkg::pkt_record_t split_words(
      input pkt_defs_pkg::word_t w0,
      input pkt_defs_pkg::word_t w1,
      input pkt_defs_pkg::word_t w2);
      pkt_defs_pkg::pkt_record_t r;
      r.f0 = w0[31:24];
      r.f1 = w0[23:8];
      r.f2 = {w1[31:24], w0[7:0]};
      r.f3 = {w2[31:24], w1[23:0]};
      r.f4 = w2[23:0];
      return r;
   endfunction

   function automatic int pick_gap(input int max_gap);
      return (max_gap == 0) ? 0 : int'($urandom_range(max_gap, 0));
   endfunction

   task automatic idle(input int cycles);
      repeat (cycles)
      begin
         @(posedge clk);
         din_v    <= 1'b0;
         acc_mark <= 1'b0;
         din      <= $urandom;
      end
   endtask

   // gap 0 leaves din_v high for the next word
   task automatic send_word(input pkt_defs_pkg::word_t w, input logic mark, input int gap);
      @(posedge clk);
      din      <= w;
      din_v    <= 1'b1;
      acc_mark <= mark;
      idle(gap);
   endtask

   task automatic send_pkt(input pkt_defs_pkg::word_t w0, input int max_gap);
      pkt_defs_pkg::word_t       w1;
      pkt_defs_pkg::word_t       w2;
      pkt_defs_pkg::pkt_record_t r;
      logic                      hit;
      w1  = $urandom;
      w2  = $urandom;
      r   = split_words(w0, w1, w2);
      hit = 1'b1;
      // a set mask bit demands that f0 carries the value bit
      for (int b = 0; b < 8; b++)
      begin
         if (m_mask[b] && r.f0[b] != m_value[b])
            hit = 1'b0;
      end
      if (hit)
      begin
         exp_q.push_back(r);
         m_accept++;
      end
      else
         m_drop++;
      send_word(w0, 1'b0, pick_gap(max_gap));
      send_word(w1, 1'b0, pick_gap(max_gap));
      send_word(w2, hit, pick_gap(max_gap));
   endtask

   // setup then access, data and pslverr sampled mid access
   task automatic apb_xfer(input logic wr, input parser_regs_pkg::apb_addr_t addr,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output logic err);
      @(posedge clk);
      apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
      @(posedge clk);
      apb_req.penable <= 1'b1;
      @(negedge clk);
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(posedge clk);
      apb_req <= '0;
   endtask

   task automatic apb_write(input parser_regs_pkg::apb_addr_t addr, input logic [31:0] wdata);
      logic [31:0] rdata;
      logic        err;
      apb_xfer(1'b1, addr, wdata, rdata, err);
      assert (!err)
      else
      begin
         errors++;
         $display("Mismatch at %0t: write to offset %h gave a slave error", $time, addr);
      end
   endtask

   task automatic check_reg(input parser_regs_pkg::apb_addr_t addr, input logic [31:0] exp,
                            input string what);
      logic [31:0] rdata;
      logic        err;
      apb_xfer(1'b0, addr, 32'h0, rdata, err);
      assert (!err && rdata == exp)
      else
      begin
         errors++;
         $display("Mismatch at %0t: %0s read %h pslverr %b, expected %h", $time, what,
                  rdata, err, exp);
      end
   endtask

   task automatic expect_err(input logic wr, input parser_regs_pkg::apb_addr_t addr,
                             input string what);
      logic [31:0] rdata;
      logic        err;
      apb_xfer(wr, addr, 32'hffff_ffff, rdata, err);
      assert (err)
      else
      begin
         errors++;
         $display("Mismatch at %0t: %0s gave no slave error", $time, what);
      end
   endtask

   task automatic report(input string name, input int start);
      if (errors == start)
         $display("%-14s ok", name);
      else
      begin
         tests_failed++;
         $display("%-14s failed, %0d errors", name, errors - start);
      end
   endtask

   initial
   begin
      #(WATCHDOG);
      $display("watchdog expired at %0t, the run did not finish", $time);
      $display("TEST FAIL");
      $finish;
   end

   initial
   begin
      int                  start;
      pkt_defs_pkg::word_t w0;
      logic [31:0]         wdata;
      void'($urandom(SEED));
      clk          = 1'b0;
      rst          = 1'b1;
      din          = '0;
      din_v        = 1'b0;
      apb_req      = '0;
      acc_mark     = 1'b0;
      m_value      = 8'h00;
      m_mask       = 8'h00;
      m_accept     = 0;
      m_drop       = 0;
      errors       = 0;
      tests_failed = 0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;

      // field split, random gaps then back to back
      start = errors;
      apb_write(parser_regs_pkg::CTRL, 32'h1);
      repeat (N_SPLIT) send_pkt($urandom, MAX_GAP);
      repeat (N_B2B) send_pkt($urandom, 0);
      idle(3);
      report("field_split", start);

      // type filter on the upper nibble of f0
      start   = errors;
      m_value = 8'($urandom);
      m_mask  = 8'hf0;
      apb_write(parser_regs_pkg::MATCH, {16'h0, m_mask, m_value});
      for (int i = 0; i < N_FILTER; i++)
      begin
         w0 = $urandom;
         // every other packet matches
         if (i % 2 == 0)
            w0[31:28] = m_value[7:4];
         send_pkt(w0, MAX_GAP);
      end
      idle(3);
      check_reg(parser_regs_pkg::ACCEPT_CNT, 32'(m_accept), "accept count");
      check_reg(parser_regs_pkg::DROP_CNT, 32'(m_drop), "drop count");
      report("filter", start);

      // words while disabled are ignored
      start   = errors;
      m_value = 8'h00;
      m_mask  = 8'h00;
      apb_write(parser_regs_pkg::MATCH, 32'h0);
      apb_write(parser_regs_pkg::CTRL, 32'h0);
      check_reg(parser_regs_pkg::STATUS, 32'h0, "status before disable");
      repeat (5) send_word($urandom, 1'b0, pick_gap(MAX_GAP));
      idle(2);
      check_reg(parser_regs_pkg::STATUS, 32'h0, "status while disabled");
      apb_write(parser_regs_pkg::CTRL, 32'h1);
      send_pkt($urandom, MAX_GAP);
      idle(3);
      report("disable", start);

      // resync after one and after two words
      start = errors;
      for (int n = 1; n <= 2; n++)
      begin
         repeat (n) send_word($urandom, 1'b0, 1);
         check_reg(parser_regs_pkg::STATUS, 32'(n), "status in partial packet");
         apb_write(parser_regs_pkg::CTRL, 32'h3);
         check_reg(parser_regs_pkg::STATUS, 32'h0, "status after resync");
         send_pkt($urandom, MAX_GAP);
         idle(3);
      end
      report("resync", start);

      // register map
      start = errors;
      wdata = {16'h0, 16'($urandom)};
      apb_write(parser_regs_pkg::MATCH, wdata);
      check_reg(parser_regs_pkg::MATCH, wdata, "match readback");
      apb_write(parser_regs_pkg::MATCH, 32'h0);
      expect_err(1'b0, 8'h14, "read of unmapped offset");
      expect_err(1'b1, 8'h20, "write to unmapped offset");
      expect_err(1'b1, parser_regs_pkg::ACCEPT_CNT, "write to accept count");
      expect_err(1'b1, parser_regs_pkg::STATUS, "write to status");
      apb_write(parser_regs_pkg::CTRL, 32'h5);
      m_accept = 0;
      m_drop   = 0;
      check_reg(parser_regs_pkg::ACCEPT_CNT, 32'h0, "accept count after clear");
      check_reg(parser_regs_pkg::DROP_CNT, 32'h0, "drop count after clear");
      report("registers", start);

      idle(2);
      $display("tests 5, failed %0d, errors %0d", tests_failed, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire
